// ==== hw/rx_credit_fifo.sv ====
/* FIFO with credit-counted output */

`timescale 1ns/1ps

module rx_credit_fifo #(
    parameter type T           = logic [7:0],
    parameter int  DEPTH       = 16,
    parameter int  NUM_CREDITS = 4
) (
    input  logic i_2711_rx_clk,
    input  logic i_rst,
    input  logic i_push,
    input  T     i_data,
    input  logic i_credit,
    output logic o_valid,
    output T     o_data,
    output logic o_overflow
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);
    localparam int KW = $clog2(NUM_CREDITS + 1);

    T              mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [KW-1:0] credits;
    logic          full;
    logic          wr_en;
    logic          rd_en;

    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] ptr);
        ptr_inc = (ptr == AW'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full  = (count == CW'(DEPTH));
    assign wr_en = i_push & ~full;

    // pop only with an item and a credit in hand
    assign rd_en = (count != '0) & (credits != '0);

    always_ff @(posedge i_2711_rx_clk) begin
        if (wr_en) begin
            mem[wr_ptr] <= i_data;
        end
        if (rd_en) begin
            o_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credits    <= KW'(NUM_CREDITS);
            o_valid    <= 1'b0;
            o_overflow <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_en) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end

            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // send and return in one cycle cancel out
            case ({rd_en, i_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;
            endcase

            o_valid <= rd_en;

            // stream cannot stall, item is lost
            if (i_push & full) begin
                o_overflow <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/rx_frame_parser.sv ====
/* RX frame parser */

`timescale 1ns/1ps

module rx_frame_parser (
    input  logic                            i_2711_rx_clk,
    input  logic                            i_rst,
    input  logic                            i_2711_rkmsb,
    input  logic                            i_2711_rklsb,
    input  logic [tlk_rx_pkg::RX_WORD_W-1:0] i_2711_rxd,
    output logic                            o_word_valid,
    output logic [tlk_rx_pkg::RX_WORD_W-1:0] o_word,
    output logic                            o_word_last,
    output logic                            o_desc_push,
    output tlk_rx_pkg::rx_frame_desc_t      o_desc,
    output logic                            o_in_frame
);

    import tlk_rx_pkg::*;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SYNC,
        ST_HEAD,
        ST_TYPE,
        ST_LINE,
        ST_LENGTH,
        ST_PAYLOAD,
        ST_CHECK,
        ST_END1,
        ST_END2
    } state_t;

    state_t               cs;
    state_t               ns;
    logic [RX_WORD_W-1:0] prev_word;
    logic [RX_WORD_W-1:0] checksum;
    logic [14:0]          word_cnt;
    logic                 sync_hit;
    logic                 start_hit;
    logic                 head_hit;
    logic                 pay_last;

    assign sync_hit  = ~i_2711_rkmsb & i_2711_rklsb & (i_2711_rxd == SYNC_WORD);
    assign start_hit = i_2711_rkmsb & i_2711_rklsb & (i_2711_rxd == START_WORD);

    // head flag spans the previous and the current word
    assign head_hit = (prev_word == HEAD_FLAG_HI) & (i_2711_rxd == HEAD_FLAG_LO);

    // length is in bytes, two bytes per word
    assign pay_last = (word_cnt == o_desc.byte_length[15:1] - 15'd1);

    ////////////////////////////////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////////////////////////////////

    always_comb begin
        ns = cs;
        case (cs)
            ST_IDLE: begin
                if (sync_hit) begin
                    ns = ST_SYNC;
                end
            end
            ST_SYNC: begin
                if (start_hit) begin
                    ns = ST_HEAD;
                end
            end
            ST_HEAD: begin
                if (head_hit) begin
                    ns = ST_TYPE;
                end
            end
            ST_TYPE:    ns = ST_LINE;
            ST_LINE:    ns = ST_LENGTH;
            ST_LENGTH:  ns = ST_PAYLOAD;
            ST_PAYLOAD: begin
                if (pay_last) begin
                    ns = ST_CHECK;
                end
            end
            ST_CHECK:   ns = ST_END1;
            ST_END1:    ns = ST_END2;
            default:    ns = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_rst) begin
            cs           <= ST_IDLE;
            checksum     <= '0;
            word_cnt     <= '0;
            o_word_valid <= 1'b0;
            o_word_last  <= 1'b0;
            o_desc_push  <= 1'b0;
            o_in_frame   <= 1'b0;
        end else begin
            cs <= ns;

            // running sum over header and payload words
            case (cs)
                ST_TYPE, ST_LINE, ST_LENGTH, ST_PAYLOAD: begin
                    checksum <= checksum + i_2711_rxd;
                end
                ST_CHECK, ST_END1, ST_END2: begin
                    checksum <= checksum;
                end
                default: begin
                    checksum <= '0;
                end
            endcase

            if (cs == ST_PAYLOAD) begin
                word_cnt <= word_cnt + 15'd1;
            end else begin
                word_cnt <= '0;
            end

            o_word_valid <= (cs == ST_PAYLOAD);
            o_word_last  <= (cs == ST_PAYLOAD) & pay_last;
            o_desc_push  <= (cs == ST_CHECK);

            // header and payload only, the loss monitor watches K flags here
            o_in_frame <= cs inside {ST_TYPE, ST_LINE, ST_LENGTH, ST_PAYLOAD};
        end
    end

    ////////////////////////////////////////////////////////////////////
    // word register and header capture
    ////////////////////////////////////////////////////////////////////

    always_ff @(posedge i_2711_rx_clk) begin
        prev_word <= i_2711_rxd;
    end

    // payload word leaves one cycle after arrival
    assign o_word = prev_word;

    always_ff @(posedge i_2711_rx_clk) begin
        case (cs)
            ST_TYPE: begin
                {o_desc.file_end, o_desc.channel_id, o_desc.data_type,
                 o_desc.line_number[23:16]} <= i_2711_rxd;
            end
            ST_LINE: begin
                o_desc.line_number[15:0] <= i_2711_rxd;
            end
            ST_LENGTH: begin
                o_desc.byte_length <= i_2711_rxd;
            end
            ST_CHECK: begin
                o_desc.checksum_ok <= (checksum == i_2711_rxd);
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== hw/rx_loss_monitor.sv ====
/* link and sync loss monitor */

`timescale 1ns/1ps

module rx_loss_monitor #(
    parameter int LOSS_HOLDOFF = 64
) (
    input  logic                            i_2711_rx_clk,
    input  logic                            i_rst,
    input  logic                            i_2711_rkmsb,
    input  logic                            i_2711_rklsb,
    input  logic [tlk_rx_pkg::RX_WORD_W-1:0] i_2711_rxd,
    input  logic                            i_in_frame,
    input  logic                            i_link_loss_detect_ena,
    input  logic                            i_sync_loss_detect_ena,
    output logic                            o_link_loss,
    output logic                            o_sync_loss
);

    import tlk_rx_pkg::*;

    localparam int HW = (LOSS_HOLDOFF > 1) ? $clog2(LOSS_HOLDOFF) : 1;

    logic [RX_WORD_W-1:0] rxd_q;
    logic                 rkmsb_q;
    logic                 rklsb_q;
    logic [1:0]           hit;
    logic [1:0]           ena;
    logic [1:0]           det_pulse;

    // raw word delayed to line up with the parser's in-frame flag
    always_ff @(posedge i_2711_rx_clk) begin
        if (i_rst) begin
            rkmsb_q <= 1'b0;
            rklsb_q <= 1'b0;
        end else begin
            rkmsb_q <= i_2711_rkmsb;
            rklsb_q <= i_2711_rklsb;
        end
        rxd_q <= i_2711_rxd;
    end

    // index 0 link loss, index 1 sync loss
    assign hit[0] = rkmsb_q & rklsb_q & (rxd_q == LINK_LOSS_WORD);
    assign hit[1] = (rkmsb_q | rklsb_q) & i_in_frame;
    assign ena    = {i_sync_loss_detect_ena, i_link_loss_detect_ena};

    for (genvar d = 0; d < 2; d++) begin : g_det
        logic          pulse;
        logic          holdoff;
        logic [HW-1:0] hold_cnt;

        // one pulse, then quiet for LOSS_HOLDOFF cycles
        always_ff @(posedge i_2711_rx_clk) begin
            if (i_rst || !ena[d]) begin
                pulse    <= 1'b0;
                holdoff  <= 1'b0;
                hold_cnt <= '0;
            end else begin
                pulse <= hit[d] & ~holdoff;
                if (hit[d] && !holdoff) begin
                    holdoff  <= 1'b1;
                    hold_cnt <= '0;
                end else if (holdoff) begin
                    if (hold_cnt == HW'(LOSS_HOLDOFF - 1)) begin
                        holdoff <= 1'b0;
                    end
                    hold_cnt <= hold_cnt + 1'b1;
                end
            end
        end

        assign det_pulse[d] = pulse;
    end

    assign o_link_loss = det_pulse[0];
    assign o_sync_loss = det_pulse[1];

endmodule

// ==== hw/rx_word_packer.sv ====
/* payload word packer */

`timescale 1ns/1ps

module rx_word_packer (
    input  logic                            i_2711_rx_clk,
    input  logic                            i_rst,
    input  logic                            i_word_valid,
    input  logic [tlk_rx_pkg::RX_WORD_W-1:0] i_word,
    input  logic                            i_word_last,
    output logic                            o_beat_push,
    output tlk_rx_pkg::rx_beat_t            o_beat
);

    import tlk_rx_pkg::*;

    localparam int LANE_W = $clog2(WORDS_PER_BEAT);

    logic [LANE_W-1:0] lane;
    logic [BEAT_W-1:0] acc;
    logic [BEAT_W-1:0] acc_next;
    logic              beat_done;

    // first word of a group starts from zero, so unused lanes stay clear
    always_comb begin
        acc_next = (lane == '0) ? '0 : acc;
        acc_next[lane*RX_WORD_W +: RX_WORD_W] = i_word;
    end

    // full beat or end of frame
    assign beat_done = i_word_valid &
                       (i_word_last | (lane == LANE_W'(WORDS_PER_BEAT - 1)));

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_rst) begin
            lane        <= '0;
            o_beat_push <= 1'b0;
        end else begin
            o_beat_push <= beat_done;
            if (i_word_valid) begin
                if (beat_done) begin
                    lane <= '0;
                end else begin
                    lane <= lane + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_2711_rx_clk) begin
        if (i_word_valid) begin
            acc <= acc_next;
        end
        if (beat_done) begin
            o_beat.data <= acc_next;
            o_beat.last <= i_word_last;
        end
    end

endmodule

// ==== hw/tlk_rx_link_top.sv ====
/* TLK2711 receive link top */

`timescale 1ns/1ps

module tlk_rx_link_top #(
    parameter int BEAT_DEPTH   = 32,
    parameter int DESC_DEPTH   = 4,
    parameter int NUM_CREDITS  = 4,
    parameter int LOSS_HOLDOFF = 64
) (
    input  logic                            i_2711_rx_clk,
    input  logic                            i_rst,
    input  logic                            i_2711_rkmsb,
    input  logic                            i_2711_rklsb,
    input  logic [tlk_rx_pkg::RX_WORD_W-1:0] i_2711_rxd,
    input  logic                            i_link_loss_detect_ena,
    input  logic                            i_sync_loss_detect_ena,
    input  logic                            i_beat_credit,
    input  logic                            i_desc_credit,
    output logic                            o_beat_valid,
    output tlk_rx_pkg::rx_beat_t            o_beat,
    output logic                            o_desc_valid,
    output tlk_rx_pkg::rx_frame_desc_t      o_desc,
    output logic                            o_beat_overflow,
    output logic                            o_desc_overflow,
    output logic                            o_link_loss,
    output logic                            o_sync_loss
);

    import tlk_rx_pkg::*;

    logic                 word_valid;
    logic [RX_WORD_W-1:0] word;
    logic                 word_last;
    logic                 desc_push;
    rx_frame_desc_t       desc;
    logic                 in_frame;
    logic                 beat_push;
    rx_beat_t             beat;

    ////////////////////////////////////////////////////////////////////
    // frame path
    ////////////////////////////////////////////////////////////////////

    rx_frame_parser u_parser (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_rst         (i_rst),
        .i_2711_rkmsb  (i_2711_rkmsb),
        .i_2711_rklsb  (i_2711_rklsb),
        .i_2711_rxd    (i_2711_rxd),
        .o_word_valid  (word_valid),
        .o_word        (word),
        .o_word_last   (word_last),
        .o_desc_push   (desc_push),
        .o_desc        (desc),
        .o_in_frame    (in_frame)
    );

    rx_word_packer u_packer (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_rst         (i_rst),
        .i_word_valid  (word_valid),
        .i_word        (word),
        .i_word_last   (word_last),
        .o_beat_push   (beat_push),
        .o_beat        (beat)
    );

    rx_credit_fifo #(
        .T           (rx_beat_t),
        .DEPTH       (BEAT_DEPTH),
        .NUM_CREDITS (NUM_CREDITS)
    ) u_beat_fifo (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_rst         (i_rst),
        .i_push        (beat_push),
        .i_data        (beat),
        .i_credit      (i_beat_credit),
        .o_valid       (o_beat_valid),
        .o_data        (o_beat),
        .o_overflow    (o_beat_overflow)
    );

    rx_credit_fifo #(
        .T           (rx_frame_desc_t),
        .DEPTH       (DESC_DEPTH),
        .NUM_CREDITS (NUM_CREDITS)
    ) u_desc_fifo (
        .i_2711_rx_clk (i_2711_rx_clk),
        .i_rst         (i_rst),
        .i_push        (desc_push),
        .i_data        (desc),
        .i_credit      (i_desc_credit),
        .o_valid       (o_desc_valid),
        .o_data        (o_desc),
        .o_overflow    (o_desc_overflow)
    );

    ////////////////////////////////////////////////////////////////////
    // loss detection
    ////////////////////////////////////////////////////////////////////

    rx_loss_monitor #(
        .LOSS_HOLDOFF (LOSS_HOLDOFF)
    ) u_loss_monitor (
        .i_2711_rx_clk          (i_2711_rx_clk),
        .i_rst                  (i_rst),
        .i_2711_rkmsb           (i_2711_rkmsb),
        .i_2711_rklsb           (i_2711_rklsb),
        .i_2711_rxd             (i_2711_rxd),
        .i_in_frame             (in_frame),
        .i_link_loss_detect_ena (i_link_loss_detect_ena),
        .i_sync_loss_detect_ena (i_sync_loss_detect_ena),
        .o_link_loss            (o_link_loss),
        .o_sync_loss            (o_sync_loss)
    );

endmodule

// ==== hw/tlk_rx_pkg.sv ====
/* TLK2711 receive link
   shared definitions */

package tlk_rx_pkg;

    ////////////////////////////////////////////////////////////////////
    // widths
    ////////////////////////////////////////////////////////////////////

    // one transceiver word, two 8b/10b bytes
    localparam int RX_WORD_W = 16;

    // output beat toward memory
    localparam int BEAT_W = 64;

    localparam int WORDS_PER_BEAT = BEAT_W / RX_WORD_W;

    ////////////////////////////////////////////////////////////////////
    // control and flag codes
    ////////////////////////////////////////////////////////////////////

    // 8b/10b special characters
    localparam logic [7:0] K28_5 = 8'hBC;
    localparam logic [7:0] D5_6  = 8'hC5;
    localparam logic [7:0] K28_2 = 8'h5C;
    localparam logic [7:0] K27_7 = 8'hFB;

    // idle sync, K flag on the low byte only
    localparam logic [RX_WORD_W-1:0] SYNC_WORD = {D5_6, K28_5};

    // frame start, K flag on both bytes
    localparam logic [RX_WORD_W-1:0] START_WORD = {K28_2, K27_7};

    // 32-bit head flag, high word first
    localparam logic [RX_WORD_W-1:0] HEAD_FLAG_HI = 16'hEB90;
    localparam logic [RX_WORD_W-1:0] HEAD_FLAG_LO = 16'hE116;

    // transceiver reports loss of signal as all ones with both K flags
    localparam logic [RX_WORD_W-1:0] LINK_LOSS_WORD = 16'hFFFF;

    ////////////////////////////////////////////////////////////////////
    // frame types
    ////////////////////////////////////////////////////////////////////

    // one payload beat, four words in lane order
    typedef struct packed {
        logic [BEAT_W-1:0] data;
        logic              last;
    } rx_beat_t;

    // per-frame header summary
    typedef struct packed {
        logic [1:0]  file_end;
        logic [1:0]  channel_id;
        logic [3:0]  data_type;
        logic [23:0] line_number;
        logic [15:0] byte_length;
        logic        checksum_ok;
    } rx_frame_desc_t;

endpackage

// ==== run_sim.sh ====
#!/bin/sh
# build and run the receive link testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_tlk_rx_link \
    -o tb_tlk_rx_link

# the log decides the result
./obj_dir/tb_tlk_rx_link > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    exit 1
fi

// ==== verification/tb_rx_model.svh ====
/* frame generator and reference model */

// one link word, applied at the next rising edge
task automatic drive_word(input logic kmsb, input logic klsb, input logic [15:0] word);
    @(posedge i_2711_rx_clk);
    i_2711_rkmsb <= kmsb;
    i_2711_rklsb <= klsb;
    i_2711_rxd   <= word;
endtask

// idle sync words between frames
task automatic send_gap(input int n);
    for (int i = 0; i < n; i++) begin
        drive_word(1'b0, 1'b1, SYNC_WORD);
    end
endtask

// k_pos selects a payload word sent with a K flag, -1 for none
task automatic send_frame(input int nbytes, input bit bad_check, input int k_pos);
    rx_frame_desc_t d;
    rx_beat_t       b;
    logic [15:0]    pay [$];
    logic [15:0]    type_word;
    logic [15:0]    sum;
    logic [63:0]    data;
    int             nwords;

    nwords        = nbytes / 2;
    d.file_end    = 2'($random(seed));
    d.channel_id  = 2'($random(seed));
    d.data_type   = 4'($random(seed));
    d.line_number = 24'($random(seed));
    d.byte_length = 16'(nbytes);
    d.checksum_ok = ~bad_check;
    type_word     = {d.file_end, d.channel_id, d.data_type, d.line_number[23:16]};

    // checksum covers the three header words and the payload
    sum  = type_word + d.line_number[15:0] + d.byte_length;
    data = '0;
    for (int i = 0; i < nwords; i++) begin
        pay.push_back(16'($random(seed)));
        sum = sum + pay[i];
        // word i goes to lane i mod 4, lowest lane first
        data[(i % 4) * 16 +: 16] = pay[i];
        if ((i % 4 == 3) || (i == nwords - 1)) begin
            b.data = data;
            b.last = (i == nwords - 1);
            beat_q.push_back(b);
            data = '0;
        end
    end
    desc_q.push_back(d);

    drive_word(1'b0, 1'b1, SYNC_WORD);
    drive_word(1'b1, 1'b1, START_WORD);
    drive_word(1'b0, 1'b0, HEAD_FLAG_HI);
    drive_word(1'b0, 1'b0, HEAD_FLAG_LO);
    drive_word(1'b0, 1'b0, type_word);
    drive_word(1'b0, 1'b0, d.line_number[15:0]);
    drive_word(1'b0, 1'b0, d.byte_length);
    for (int i = 0; i < nwords; i++) begin
        drive_word(i == k_pos, 1'b0, pay[i]);
    end
    drive_word(1'b0, 1'b0, bad_check ? sum + 16'd1 : sum);

    // two end words, content ignored
    drive_word(1'b0, 1'b0, 16'($random(seed)));
    drive_word(1'b0, 1'b0, 16'($random(seed)));
endtask

// ==== verification/tb_tlk_rx_link.sv ====
/* TLK2711 receive link testbench */

`timescale 1ns/1ps

module tb_tlk_rx_link;

    import tlk_rx_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int SEED         = 70834;
    localparam int BEAT_DEPTH   = 32;
    localparam int DESC_DEPTH   = 4;
    localparam int NUM_CREDITS  = 4;
    localparam int LOSS_HOLDOFF = 64;

    // test length and watchdog sizing
    localparam int N_CLEAN         = 30;
    localparam int N_BAD           = 4;
    localparam int N_OVF           = DESC_DEPTH + NUM_CREDITS + 2;
    localparam int N_FRAMES        = N_CLEAN + N_BAD + N_OVF + 3;
    localparam int FRAME_MAX_WORDS = 10 + 32;
    localparam int MAX_GAP         = 7;
    localparam int LOSS_WORDS      = 2 * LOSS_HOLDOFF + 40;
    localparam int DRAIN_CYCLES    = 200;
    localparam int WATCHDOG_CYCLES = N_FRAMES * (FRAME_MAX_WORDS + MAX_GAP)
                                     + LOSS_WORDS + 6 * DRAIN_CYCLES;

    logic                 i_2711_rx_clk = 1'b0;
    logic                 i_rst;
    logic                 i_2711_rkmsb;
    logic                 i_2711_rklsb;
    logic [RX_WORD_W-1:0] i_2711_rxd;
    logic                 i_link_loss_detect_ena;
    logic                 i_sync_loss_detect_ena;
    logic                 i_beat_credit = 1'b0;
    logic                 i_desc_credit = 1'b0;
    logic                 o_beat_valid;
    rx_beat_t             o_beat;
    logic                 o_desc_valid;
    rx_frame_desc_t       o_desc;
    logic                 o_beat_overflow;
    logic                 o_desc_overflow;
    logic                 o_link_loss;
    logic                 o_sync_loss;

    int             seed        = SEED;
    int             credit_seed = SEED + 1;
    rx_beat_t       beat_q [$];
    rx_frame_desc_t desc_q [$];
    rx_beat_t       exp_beat;
    rx_frame_desc_t exp_desc;
    int             beat_avail = NUM_CREDITS;
    int             desc_avail = NUM_CREDITS;
    int             beat_recv;
    int             beat_ret;
    int             beat_delay;
    int             desc_recv;
    int             desc_ret;
    int             desc_delay;
    bit             hold_beat;
    bit             hold_desc;
    int             cyc;
    int             link_inj_cyc;
    int             link_cnt;
    int             sync_cnt;
    int             exp_link;
    int             exp_sync;
    int             beat_base;
    int             desc_base;

    tlk_rx_link_top #(
        .BEAT_DEPTH   (BEAT_DEPTH),
        .DESC_DEPTH   (DESC_DEPTH),
        .NUM_CREDITS  (NUM_CREDITS),
        .LOSS_HOLDOFF (LOSS_HOLDOFF)
    ) u_dut (
        .i_2711_rx_clk          (i_2711_rx_clk),
        .i_rst                  (i_rst),
        .i_2711_rkmsb           (i_2711_rkmsb),
        .i_2711_rklsb           (i_2711_rklsb),
        .i_2711_rxd             (i_2711_rxd),
        .i_link_loss_detect_ena (i_link_loss_detect_ena),
        .i_sync_loss_detect_ena (i_sync_loss_detect_ena),
        .i_beat_credit          (i_beat_credit),
        .i_desc_credit          (i_desc_credit),
        .o_beat_valid           (o_beat_valid),
        .o_beat                 (o_beat),
        .o_desc_valid           (o_desc_valid),
        .o_desc                 (o_desc),
        .o_beat_overflow        (o_beat_overflow),
        .o_desc_overflow        (o_desc_overflow),
        .o_link_loss            (o_link_loss),
        .o_sync_loss            (o_sync_loss)
    );

    always #(CLK_PERIOD / 2) i_2711_rx_clk = ~i_2711_rx_clk;

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp) begin
            report_error($sformatf("FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    `include "tb_rx_model.svh"

    function automatic bit outputs_busy(input bit beats_only);
        outputs_busy = (beat_q.size() != 0) || (beat_recv != beat_ret) ||
                       (!beats_only && ((desc_q.size() != 0) || (desc_recv != desc_ret)));
    endfunction

    // wait for expected items and all credit returns
    task automatic wait_drain(input bit beats_only);
        int n;
        n = 0;
        while (outputs_busy(beats_only) && n < DRAIN_CYCLES) begin
            @(posedge i_2711_rx_clk);
            n++;
        end
        if (outputs_busy(beats_only)) begin
            report_error("expected output items did not arrive in time");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // output monitor sampled on the falling edge
    //////////////////////////////////////////////////////////////////////

    always @(negedge i_2711_rx_clk) begin
        cyc++;
        if (o_beat_valid) begin
            if (beat_avail == 0) begin
                report_error("o_beat_valid was raised with no beat credit left");
            end
            beat_avail--;
            if (beat_q.size() == 0) begin
                report_error("a beat was delivered when none was expected");
            end
            exp_beat = beat_q.pop_front();
            check_value("o_beat", 128'(o_beat), 128'(exp_beat));
            beat_recv++;
        end
        if (o_desc_valid) begin
            if (desc_avail == 0) begin
                report_error("o_desc_valid was raised with no descriptor credit left");
            end
            desc_avail--;
            if (desc_q.size() == 0) begin
                report_error("a descriptor was delivered when none was expected");
            end
            exp_desc = desc_q.pop_front();
            check_value("o_desc", 128'(o_desc), 128'(exp_desc));
            desc_recv++;
        end
        if (i_beat_credit) begin
            beat_avail++;
        end
        if (i_desc_credit) begin
            desc_avail++;
        end

        // link loss pulse is due two cycles after the word
        if (o_link_loss) begin
            link_cnt++;
            check_value("o_link_loss latency", 128'(cyc - link_inj_cyc), 128'(2));
        end
        if (o_sync_loss) begin
            sync_cnt++;
        end
        if (i_2711_rkmsb && i_2711_rklsb && i_2711_rxd == LINK_LOSS_WORD) begin
            link_inj_cyc = cyc;
        end
    end

    // credit return with one pulse per cycle after a random delay
    always @(posedge i_2711_rx_clk) begin
        i_beat_credit <= 1'b0;
        i_desc_credit <= 1'b0;
        if (beat_delay > 0) begin
            beat_delay--;
        end else if (beat_recv != beat_ret && !hold_beat) begin
            i_beat_credit <= 1'b1;
            beat_ret++;
            beat_delay = $random(credit_seed) & 3;
        end
        if (desc_delay > 0) begin
            desc_delay--;
        end else if (desc_recv != desc_ret && !hold_desc) begin
            i_desc_credit <= 1'b1;
            desc_ret++;
            desc_delay = $random(credit_seed) & 3;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        i_rst                  = 1'b1;
        i_2711_rkmsb           = 1'b0;
        i_2711_rklsb           = 1'b1;
        i_2711_rxd             = SYNC_WORD;
        i_link_loss_detect_ena = 1'b1;
        i_sync_loss_detect_ena = 1'b1;
        repeat (5) @(posedge i_2711_rx_clk);
        i_rst <= 1'b0;
        @(negedge i_2711_rx_clk);
        check_value("outputs after reset", 128'({o_beat_valid, o_desc_valid, o_beat_overflow,
                    o_desc_overflow, o_link_loss, o_sync_loss}), '0);

        // clean frames and then frames with a wrong check word
        for (int f = 0; f < N_CLEAN; f++) begin
            send_frame(2 * (1 + ($random(seed) & 31)), 1'b0, -1);
            send_gap($random(seed) & MAX_GAP);
        end
        wait_drain(1'b0);
        for (int f = 0; f < N_BAD; f++) begin
            send_frame(2 * (1 + ($random(seed) & 31)), 1'b1, -1);
            send_gap($random(seed) & MAX_GAP);
        end
        wait_drain(1'b0);
        check_value("o_link_loss pulses", 128'(link_cnt), 128'(exp_link));
        check_value("o_sync_loss pulses", 128'(sync_cnt), 128'(exp_sync));

        // a link loss repeated inside the holdoff stays silent
        send_gap(4);
        drive_word(1'b1, 1'b1, LINK_LOSS_WORD);
        exp_link++;
        send_gap(20);
        drive_word(1'b1, 1'b1, LINK_LOSS_WORD);
        send_gap(8);
        check_value("o_link_loss pulses", 128'(link_cnt), 128'(exp_link));
        send_gap(LOSS_HOLDOFF);
        drive_word(1'b1, 1'b1, LINK_LOSS_WORD);
        exp_link++;
        send_gap(4);
        check_value("o_link_loss pulses", 128'(link_cnt), 128'(exp_link));

        // K flag in payload with and without sync loss detection
        send_frame(16, 1'b0, 2);
        exp_sync++;
        send_gap(4);
        check_value("o_sync_loss pulses", 128'(sync_cnt), 128'(exp_sync));
        @(posedge i_2711_rx_clk);
        i_sync_loss_detect_ena <= 1'b0;
        send_frame(16, 1'b0, 1);
        send_gap(4);
        check_value("o_sync_loss pulses", 128'(sync_cnt), 128'(exp_sync));
        @(posedge i_2711_rx_clk);
        i_sync_loss_detect_ena <= 1'b1;
        wait_drain(1'b0);

        // beat credits withheld over an eight beat frame
        hold_beat = 1'b1;
        beat_base = beat_recv;
        send_frame(64, 1'b0, -1);
        send_gap(8);
        check_value("beats sent on held credits", 128'(beat_recv - beat_base),
                    128'(NUM_CREDITS));
        hold_beat = 1'b0;
        wait_drain(1'b0);

        // descriptor credits withheld until the FIFO overflows
        hold_desc = 1'b1;
        desc_base = desc_recv;
        for (int f = 0; f < N_OVF; f++) begin
            send_frame(2 * (1 + ($random(seed) & 31)), 1'b0, -1);
            send_gap($random(seed) & MAX_GAP);
        end
        send_gap(8);
        wait_drain(1'b1);
        @(negedge i_2711_rx_clk);
        check_value("o_desc_overflow", 128'(o_desc_overflow), 128'(1));

        // only the earliest frames survive
        while (desc_recv - desc_base + desc_q.size() > DESC_DEPTH + NUM_CREDITS) begin
            void'(desc_q.pop_back());
        end
        hold_desc = 1'b0;
        wait_drain(1'b0);
        @(negedge i_2711_rx_clk);
        check_value("o_beat_overflow", 128'(o_beat_overflow), 128'(0));

        if (beat_q.size() != 0 || desc_q.size() != 0) begin
            report_error("expected items were still queued at the end of the run");
        end else begin
            $display("test passed");
            $finish;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_error("watchdog expired, the run took longer than the tests allow");
    end

endmodule

// ==== verilog.f ====
+incdir+verification
hw/tlk_rx_pkg.sv
hw/rx_frame_parser.sv
hw/rx_word_packer.sv
hw/rx_credit_fifo.sv
hw/rx_loss_monitor.sv
hw/tlk_rx_link_top.sv
verification/tb_tlk_rx_link.sv
